//--- hdl/mem_test_macros.svh
`ifndef MEM_TEST_MACROS_SVH
`define MEM_TEST_MACROS_SVH

// AXI bus widths
`define MT_ADDR_WIDTH 20
`define MT_DATA_WIDTH 16
`define MT_ID_WIDTH 4
`define MT_STRB_WIDTH (`MT_DATA_WIDTH / 8)

// burst layout of one test pass
`define MT_NUM_BURSTS 8
`define MT_NUM_BEATS 3
`define MT_BYTES_PER_BURST (`MT_STRB_WIDTH * `MT_NUM_BEATS)

// every transfer uses the full bus width and INCR addressing
`define MT_AXSIZE ($clog2(`MT_STRB_WIDTH))
`define MT_BURST_INCR 2'b01
`define MT_RESP_OKAY 2'b00

// words in the test memory, must cover bursts times beats
`define MT_MEM_WORDS 64

`endif

//--- hdl/mem_test_pkg.sv
`include "mem_test_macros.svh"

package mem_test_pkg;

  typedef logic [`MT_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`MT_DATA_WIDTH-1:0] data_t;
  typedef logic [`MT_ID_WIDTH-1:0]   id_t;
  typedef logic [7:0]                axlen_t;

  // burst, beat and run counters
  typedef logic [7:0]                count_t;

  // sequencing of the write and read engines
  typedef enum logic [2:0] {
    st_idle,
    st_burst_init,
    st_burst,
    st_done,
    st_fail
  } test_state_t;

  // the memory serves one burst at a time
  typedef enum logic [1:0] {
    mem_idle,
    mem_write,
    mem_read
  } mem_state_t;

endpackage

//--- hdl/mem_test_writer.sv
`include "mem_test_macros.svh"

module mem_test_writer
  import mem_test_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  data_t                     pattern_base,
  output logic                      write_done,

  output logic                      awvalid,
  output addr_t                     awaddr,
  output id_t                       awid,
  output axlen_t                    awlen,
  output logic [2:0]                awsize,
  output logic [1:0]                awburst,
  input  logic                      awready,
  output logic                      wvalid,
  output data_t                     wdata,
  output logic [`MT_STRB_WIDTH-1:0] wstrb,
  output logic                      wlast,
  input  logic                      wready,
  input  logic                      bvalid,
  input  id_t                       bid,
  input  logic [1:0]                bresp,
  output logic                      bready
);

  localparam count_t num_bursts = count_t'(`MT_NUM_BURSTS);
  localparam count_t num_beats  = count_t'(`MT_NUM_BEATS);

  test_state_t state;
  test_state_t state_next;
  addr_t       burst_addr;
  addr_t       burst_addr_next;
  count_t      burst_cnt;
  count_t      burst_cnt_next;
  count_t      beat_cnt;
  count_t      beat_cnt_next;
  count_t      data_cnt;
  count_t      data_cnt_next;
  data_t       data_calc;

  logic        awvalid_next;
  addr_t       awaddr_next;
  axlen_t      awlen_next;
  logic        wvalid_next;
  data_t       wdata_next;
  logic        wlast_next;

  assign awid    = '0;
  assign awsize  = 3'(`MT_AXSIZE);
  assign awburst = `MT_BURST_INCR;
  assign wstrb   = '1;
  assign bready  = 1'b1;

  assign write_done = (state == st_done);

  // the pattern runs on across bursts, so beat k of the pass carries base + k
  assign data_calc = pattern_base + data_t'(data_cnt);

  always_comb begin
    state_next      = state;
    burst_addr_next = burst_addr;
    burst_cnt_next  = burst_cnt;
    beat_cnt_next   = beat_cnt;
    data_cnt_next   = data_cnt;

    awvalid_next    = awvalid && !awready;
    awaddr_next     = awaddr;
    awlen_next      = awlen;
    wvalid_next     = wvalid && !wready;
    wdata_next      = wdata;
    wlast_next      = wlast;

    case (state)
      st_idle: begin
        if (start) begin
          state_next      = st_burst_init;
          burst_addr_next = '0;
          burst_cnt_next  = '0;
          beat_cnt_next   = '0;
          data_cnt_next   = '0;
        end
      end

      st_burst_init: begin
        if (!awvalid || awready) begin
          state_next     = st_burst;
          awvalid_next   = 1'b1;
          awaddr_next    = burst_addr;
          awlen_next     = axlen_t'(`MT_NUM_BEATS - 1);

          // first W beat goes out together with the address
          burst_cnt_next = burst_cnt + 1'b1;
          beat_cnt_next  = count_t'(1);
          data_cnt_next  = data_cnt + 1'b1;
          wvalid_next    = 1'b1;
          wdata_next     = data_calc;
          wlast_next     = (beat_cnt_next == num_beats);
        end
      end

      st_burst: begin
        if (wvalid && wready && (beat_cnt != num_beats)) begin
          beat_cnt_next = beat_cnt + 1'b1;
          data_cnt_next = data_cnt + 1'b1;
          wvalid_next   = 1'b1;
          wdata_next    = data_calc;
          wlast_next    = (beat_cnt_next == num_beats);
        end

        if (bvalid && bready) begin
          if (burst_cnt != num_bursts) begin
            state_next      = st_burst_init;
            burst_addr_next = burst_addr + addr_t'(`MT_BYTES_PER_BURST);
          end else begin
            state_next = st_done;
          end
        end
      end

      st_done: begin
        state_next = st_idle;
      end

      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      awvalid   <= 1'b0;
      wvalid    <= 1'b0;
      burst_cnt <= '0;
      beat_cnt  <= '0;
      data_cnt  <= '0;
    end else begin
      state     <= state_next;
      awvalid   <= awvalid_next;
      wvalid    <= wvalid_next;
      burst_cnt <= burst_cnt_next;
      beat_cnt  <= beat_cnt_next;
      data_cnt  <= data_cnt_next;
    end
  end

  always_ff @(posedge clk) begin
    burst_addr <= burst_addr_next;
    awaddr     <= awaddr_next;
    awlen      <= awlen_next;
    wdata      <= wdata_next;
    wlast      <= wlast_next;
  end

  a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

  // the running beat count of the pass marks where each burst ends
  a_wlast_beat: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid |-> (wlast == (data_cnt == burst_cnt * num_beats)));

endmodule

//--- hdl/mem_test_reader.sv
`include "mem_test_macros.svh"

module mem_test_reader
  import mem_test_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       write_done,
  input  data_t      pattern_base,

  output logic       arvalid,
  output id_t        arid,
  output addr_t      araddr,
  output axlen_t     arlen,
  output logic [2:0] arsize,
  output logic [1:0] arburst,
  input  logic       arready,
  input  logic       rvalid,
  input  id_t        rid,
  input  data_t      rdata,
  input  logic [1:0] rresp,
  input  logic       rlast,
  output logic       rready,

  output logic       test_done,
  output logic       test_pass,
  output logic [7:0] debug0,
  output logic [7:0] debug1,
  output logic [7:0] debug2
);

  localparam count_t num_bursts = count_t'(`MT_NUM_BURSTS);

  test_state_t state;
  test_state_t state_next;
  addr_t       burst_addr;
  addr_t       burst_addr_next;
  count_t      burst_cnt;
  count_t      burst_cnt_next;
  count_t      data_cnt;
  count_t      data_cnt_next;
  count_t      run_cnt;
  data_t       expected_calc;
  data_t       actual;
  data_t       actual_next;
  data_t       expected;
  data_t       expected_next;
  logic        test_pass_next;

  logic        arvalid_next;
  addr_t       araddr_next;
  axlen_t      arlen_next;

  assign arid    = '0;
  assign arsize  = 3'(`MT_AXSIZE);
  assign arburst = `MT_BURST_INCR;
  assign rready  = 1'b1;

  assign test_done = (state == st_done);

  assign expected_calc = pattern_base + data_t'(data_cnt);

  always_comb begin
    state_next      = state;
    burst_addr_next = burst_addr;
    burst_cnt_next  = burst_cnt;
    data_cnt_next   = data_cnt;
    actual_next     = actual;
    expected_next   = expected;
    test_pass_next  = test_pass;

    arvalid_next    = arvalid && !arready;
    araddr_next     = araddr;
    arlen_next      = arlen;

    case (state)
      st_idle: begin
        if (write_done) begin
          state_next      = st_burst_init;
          burst_addr_next = '0;
          burst_cnt_next  = '0;
          data_cnt_next   = '0;
          test_pass_next  = 1'b1;
        end
      end

      st_burst_init: begin
        if (!arvalid || arready) begin
          state_next     = st_burst;
          arvalid_next   = 1'b1;
          araddr_next    = burst_addr;
          arlen_next     = axlen_t'(`MT_NUM_BEATS - 1);
          burst_cnt_next = burst_cnt + 1'b1;
        end
      end

      st_burst: begin
        if (rvalid && rready) begin
          data_cnt_next = data_cnt + 1'b1;
          actual_next   = rdata;
          expected_next = expected_calc;

          if (rdata != expected_calc) begin
            // beats left in this burst still have to be taken off the bus
            test_pass_next = 1'b0;
            state_next     = rlast ? st_done : st_fail;
          end else if (rlast) begin
            if (burst_cnt != num_bursts) begin
              state_next      = st_burst_init;
              burst_addr_next = burst_addr + addr_t'(`MT_BYTES_PER_BURST);
            end else begin
              state_next = st_done;
            end
          end
        end
      end

      st_fail: begin
        if (rvalid && rready && rlast) begin
          state_next = st_done;
        end
      end

      st_done: begin
        state_next = st_idle;
      end

      default: begin
        state_next = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      arvalid   <= 1'b0;
      test_pass <= 1'b1;
      burst_cnt <= '0;
      data_cnt  <= '0;
    end else begin
      state     <= state_next;
      arvalid   <= arvalid_next;
      test_pass <= test_pass_next;
      burst_cnt <= burst_cnt_next;
      data_cnt  <= data_cnt_next;
    end
  end

  always_ff @(posedge clk) begin
    burst_addr <= burst_addr_next;
    araddr     <= araddr_next;
    arlen      <= arlen_next;
    actual     <= actual_next;
    expected   <= expected_next;
  end

  // counts every finished run, failed ones too
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_cnt <= '0;
    end else if (state == st_done) begin
      run_cnt <= run_cnt + 1'b1;
    end
  end

  assign debug0 = actual[7:0];
  assign debug1 = expected[7:0];
  assign debug2 = run_cnt;

  a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

endmodule

//--- hdl/axi_mem.sv
`include "mem_test_macros.svh"

module axi_mem
  import mem_test_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      stall,
  input  data_t                     fault_mask,

  input  logic                      awvalid,
  input  addr_t                     awaddr,
  input  id_t                       awid,
  input  axlen_t                    awlen,
  input  logic [2:0]                awsize,
  input  logic [1:0]                awburst,
  output logic                      awready,
  input  logic                      wvalid,
  input  data_t                     wdata,
  input  logic [`MT_STRB_WIDTH-1:0] wstrb,
  input  logic                      wlast,
  output logic                      wready,
  output logic                      bvalid,
  output id_t                       bid,
  output logic [1:0]                bresp,
  input  logic                      bready,

  input  logic                      arvalid,
  input  id_t                       arid,
  input  addr_t                     araddr,
  input  axlen_t                    arlen,
  input  logic [2:0]                arsize,
  input  logic [1:0]                arburst,
  output logic                      arready,
  output logic                      rvalid,
  output id_t                       rid,
  output data_t                     rdata,
  output logic [1:0]                rresp,
  output logic                      rlast,
  input  logic                      rready
);

  localparam int idx_width  = $clog2(`MT_MEM_WORDS);
  localparam int byte_shift = $clog2(`MT_STRB_WIDTH);

  data_t                mem [`MT_MEM_WORDS];
  mem_state_t           state;
  logic [idx_width-1:0] idx;
  axlen_t               beats_left;
  id_t                  burst_id;
  data_t                wdata_masked;
  logic                 rd_end;
  logic                 rd_next;

  // AW wins when both address channels are valid in the same cycle
  assign awready = (state == mem_idle) && !stall && awvalid;
  assign arready = (state == mem_idle) && !stall && !awvalid && arvalid;
  assign wready  = (state == mem_write) && !stall && !bvalid;

  assign bid   = burst_id;
  assign rid   = burst_id;
  assign bresp = `MT_RESP_OKAY;
  assign rresp = `MT_RESP_OKAY;

  // faulty cells read back as zero whatever is written
  assign wdata_masked = wdata & ~fault_mask;

  assign rd_end  = rvalid && rready && rlast;
  assign rd_next = (state == mem_read) && !rd_end && (!rvalid || rready) && !stall;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= mem_idle;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      case (state)
        mem_idle: begin
          if (awvalid && awready) begin
            state <= mem_write;
          end else if (arvalid && arready) begin
            state <= mem_read;
          end
        end

        mem_write: begin
          if (wvalid && wready && wlast) begin
            bvalid <= 1'b1;
          end
          if (bvalid && bready) begin
            bvalid <= 1'b0;
            state  <= mem_idle;
          end
        end

        mem_read: begin
          if (rd_end) begin
            rvalid <= 1'b0;
            state  <= mem_idle;
          end else if (!rvalid || rready) begin
            // a stall leaves a gap, but a beat already on the bus stays put
            rvalid <= !stall;
          end
        end

        default: begin
          state <= mem_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) begin
      idx        <= awaddr[byte_shift +: idx_width];
      beats_left <= awlen;
      burst_id   <= awid;
    end else if (arvalid && arready) begin
      idx        <= araddr[byte_shift +: idx_width];
      beats_left <= arlen;
      burst_id   <= arid;
    end else if (wvalid && wready) begin
      for (int b = 0; b < `MT_STRB_WIDTH; b++) begin
        if (wstrb[b]) begin
          mem[idx][b*8 +: 8] <= wdata_masked[b*8 +: 8];
        end
      end
      idx        <= idx + 1'b1;
      beats_left <= beats_left - 1'b1;
    end else if (rd_next) begin
      rdata      <= mem[idx];
      rlast      <= (beats_left == '0);
      idx        <= idx + 1'b1;
      beats_left <= beats_left - 1'b1;
    end
  end

  // the last W beat has to land where awlen said the burst ends
  a_w_last_beat: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && wready |-> (wlast == (beats_left == '0)));

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast));

  // only full-width INCR bursts are served
  a_burst_kind: assert property (@(posedge clk) disable iff (!rst_n)
    (awvalid |-> awburst == `MT_BURST_INCR && awsize == 3'(`MT_AXSIZE)) and
    (arvalid |-> arburst == `MT_BURST_INCR && arsize == 3'(`MT_AXSIZE)));

endmodule

//--- hdl/mem_test_top.sv
`include "mem_test_macros.svh"

module mem_test_top
  import mem_test_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  data_t      pattern_base,
  input  logic       mem_stall,
  input  data_t      fault_mask,
  output logic       test_done,
  output logic       test_pass,
  output logic [7:0] debug0,
  output logic [7:0] debug1,
  output logic [7:0] debug2
);

  logic                      write_done;

  // write side of the bus
  logic                      awvalid;
  addr_t                     awaddr;
  id_t                       awid;
  axlen_t                    awlen;
  logic [2:0]                awsize;
  logic [1:0]                awburst;
  logic                      awready;
  logic                      wvalid;
  data_t                     wdata;
  logic [`MT_STRB_WIDTH-1:0] wstrb;
  logic                      wlast;
  logic                      wready;
  logic                      bvalid;
  id_t                       bid;
  logic [1:0]                bresp;
  logic                      bready;

  // read side of the bus
  logic                      arvalid;
  id_t                       arid;
  addr_t                     araddr;
  axlen_t                    arlen;
  logic [2:0]                arsize;
  logic [1:0]                arburst;
  logic                      arready;
  logic                      rvalid;
  id_t                       rid;
  data_t                     rdata;
  logic [1:0]                rresp;
  logic                      rlast;
  logic                      rready;

  mem_test_writer u_writer (.*);

  mem_test_reader u_reader (.*);

  axi_mem u_mem (
    .stall (mem_stall),
    .*
  );

endmodule

//--- test/mem_test_tb.sv
`include "mem_test_macros.svh"

module mem_test_tb
  import mem_test_pkg::*;
();

  typedef enum logic [1:0] {
    stall_off,
    stall_toggle,
    stall_random
  } stall_mode_t;

  localparam int num_rows      = 8;
  localparam int timeout_limit = num_rows * 600;

  logic       clk;
  logic       rst_n;
  logic       start;
  data_t      pattern_base;
  logic       mem_stall;
  data_t      fault_mask;
  logic       test_done;
  logic       test_pass;
  logic [7:0] debug0;
  logic [7:0] debug1;
  logic [7:0] debug2;

  // stimulus table, one entry per run
  data_t       tbl_base [num_rows];
  stall_mode_t tbl_mode [num_rows];
  data_t       tbl_mask [num_rows];
  logic        tbl_pass [num_rows];
  data_t       tbl_act  [num_rows];
  data_t       tbl_exp  [num_rows];

  stall_mode_t stall_mode;
  integer      seed;
  integer      rnd;
  int          cycle_count;
  int          done_count;
  int          error_count;
  int          check_count;
  int          row_errors;
  logic        done_seen;

  mem_test_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .pattern_base (pattern_base),
    .mem_stall    (mem_stall),
    .fault_mask   (fault_mask),
    .test_done    (test_done),
    .test_pass    (test_pass),
    .debug0       (debug0),
    .debug1       (debug1),
    .debug2       (debug2)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // back-pressure on the memory follows the mode of the current row
  always @(negedge clk) begin
    case (stall_mode)
      stall_toggle: mem_stall = ~mem_stall;
      stall_random: begin
        rnd       = $random(seed);
        mem_stall = rnd[0];
      end
      default: mem_stall = 1'b0;
    endcase
  end

  always @(posedge clk) begin
    if (rst_n && test_done) begin
      done_count = done_count + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("run timed out after %0d cycles without finishing all tests", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_count = check_count + 1;
    if (got !== exp) begin
      error_count = error_count + 1;
      row_errors  = row_errors + 1;
      $display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // debug bytes carry the low byte of a data word
  task automatic check_data(input string what, input logic [7:0] got, input data_t exp);
    check_count = check_count + 1;
    if (got !== exp[7:0]) begin
      error_count = error_count + 1;
      row_errors  = row_errors + 1;
      $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, what, got, exp[7:0]);
    end
  endtask

  task automatic check_run_count(input string what, input logic [7:0] got, input count_t exp);
    check_count = check_count + 1;
    if (got !== exp) begin
      error_count = error_count + 1;
      row_errors  = row_errors + 1;
      $display("CHECK FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic load_row(input int idx, input data_t base, input stall_mode_t mode,
                          input data_t mask, input logic pass, input data_t act,
                          input data_t exp);
    tbl_base[idx] = base;
    tbl_mode[idx] = mode;
    tbl_mask[idx] = mask;
    tbl_pass[idx] = pass;
    tbl_act[idx]  = act;
    tbl_exp[idx]  = exp;
  endtask

  initial begin
    rst_n        = 1'b0;
    start        = 1'b0;
    pattern_base = '0;
    mem_stall    = 1'b0;
    fault_mask   = '0;
    stall_mode   = stall_off;
    seed         = 32'h3b74_47e3;
    cycle_count  = 0;
    done_count   = 0;
    error_count  = 0;
    check_count  = 0;
    row_errors   = 0;

    // a passing run ends on beat 23, a failing one on the first masked beat
    load_row(0, 16'h00D0, stall_off,    16'h0000, 1'b1, 16'h00E7, 16'h00E7);
    load_row(1, 16'h1234, stall_toggle, 16'h0000, 1'b1, 16'h124B, 16'h124B);
    load_row(2, 16'hABCD, stall_random, 16'h0000, 1'b1, 16'hABE4, 16'hABE4);
    load_row(3, 16'h00E8, stall_off,    16'h0010, 1'b0, 16'h00E0, 16'h00F0);
    load_row(4, 16'h0100, stall_random, 16'h0004, 1'b0, 16'h0100, 16'h0104);
    load_row(5, 16'h00D0, stall_off,    16'h0000, 1'b1, 16'h00E7, 16'h00E7);
    load_row(6, 16'hFFF0, stall_toggle, 16'h0000, 1'b1, 16'h0007, 16'h0007);
    load_row(7, 16'h0000, stall_toggle, 16'h8001, 1'b0, 16'h0000, 16'h0001);

    repeat (8) begin
      @(negedge clk);
      check_bit("test_done during reset", test_done, 1'b0);
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("test_pass after reset", test_pass, 1'b1);
    if (row_errors != 0) begin
      $display("reset checks: %0d errors", row_errors);
    end

    for (int r = 0; r < num_rows; r++) begin
      row_errors   = 0;
      stall_mode   = tbl_mode[r];
      pattern_base = tbl_base[r];
      fault_mask   = tbl_mask[r];
      repeat (2) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;

      done_seen = 1'b0;
      while (!done_seen) begin
        if (test_done) begin
          done_seen = 1'b1;
        end else begin
          @(negedge clk);
        end
      end

      check_bit("test_pass at done", test_pass, tbl_pass[r]);
      check_data("debug0 actual", debug0, tbl_act[r]);
      check_data("debug1 expected", debug1, tbl_exp[r]);

      // let the run counter settle and catch any second done pulse
      repeat (10) @(negedge clk);
      check_bit("test_pass after done", test_pass, tbl_pass[r]);
      check_run_count("debug2 run count", debug2, count_t'(r + 1));
      check_bit("single done pulse", done_count == r + 1, 1'b1);

      $display("test %0d: base %h mask %h stall mode %0d, test_pass %b, %s", r,
               tbl_base[r], tbl_mask[r], tbl_mode[r], test_pass,
               (row_errors == 0) ? "ok" : "mismatch");
    end

    $display("tests %0d, checks %0d, errors %0d", num_rows, check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/mem_test_pkg.sv
hdl/mem_test_writer.sv
hdl/mem_test_reader.sv
hdl/axi_mem.sv
hdl/mem_test_top.sv
test/mem_test_tb.sv

//--- Bender.yml
package:
  name: mem_test

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_test_pkg.sv
      - hdl/mem_test_writer.sv
      - hdl/mem_test_reader.sv
      - hdl/axi_mem.sv
      - hdl/mem_test_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - test/mem_test_tb.sv
